// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ns -j 0
TOP      := icache_tb
FILELIST := filelist.f
OBJ_DIR  := obj_dir

.PHONY: sim clean

# The run passes only when the pass line shows up in the output
sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
icache_pkg.sv
icache_if.sv
icache_ram.sv
icache_arrays.sv
icache_lookup.sv
icache_refill.sv
icache_flush.sv
icache_ctrl.sv
icache_top.sv
icache_tb_asserts.sv
icache_tb.sv

// ==== icache_arrays.sv ====
// Per-way tag and data RAMs with flush over refill write port priority
`timescale 1ns/1ns

module icache_arrays import icache_pkg::*; #(
  parameter int unsigned WaysWidth = 2,
  parameter int unsigned SetsWidth = 6
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  icache_wr_if.array   flush_wr,
  icache_wr_if.array   refill_wr,
  icache_rd_if.array   rd
);

  localparam int unsigned NumWays = 2 ** WaysWidth;
  localparam int unsigned TagWidth = PhysAddrLen - LineOffsetBits - SetsWidth;

  typedef struct packed {
    logic                valid;
    logic [TagWidth-1:0] tag;
  } tag_t;

  logic                    wr_tag_req;
  logic                    wr_data_req;
  logic [NumWays-1:0]      wr_ways;
  logic [SetsWidth-1:0]    wr_set;
  logic [LineBeatsLog-1:0] wr_beat;
  tag_t                    wr_tag;
  beat_t                   wr_data;

  ////////////////////////////////////////////////////////////////////////////
  // Write port select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (flush_wr.tag_req || flush_wr.data_req) begin
      wr_tag_req  = flush_wr.tag_req;
      wr_data_req = flush_wr.data_req;
      wr_ways     = flush_wr.way;
      wr_set      = flush_wr.set;
      wr_beat     = flush_wr.beat;
      wr_tag      = '{valid: flush_wr.valid, tag: flush_wr.tag};
      wr_data     = flush_wr.data;
    end else begin
      wr_tag_req  = refill_wr.tag_req;
      wr_data_req = refill_wr.data_req;
      wr_ways     = refill_wr.way;
      wr_set      = refill_wr.set;
      wr_beat     = refill_wr.beat;
      wr_tag      = '{valid: refill_wr.valid, tag: refill_wr.tag};
      wr_data     = refill_wr.data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Way storage
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumWays; i++) begin : g_way
    tag_t rd_tag;

    icache_ram #(
      .entry_t (tag_t),
      .Depth   (2 ** SetsWidth)
    ) u_tag_ram (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .rd_req_i  (rd.read_req),
      .rd_addr_i (rd.set),
      .rd_data_o (rd_tag),
      .wr_req_i  (wr_tag_req && wr_ways[i]),
      .wr_addr_i (wr_set),
      .wr_data_i (wr_tag)
    );

    // Data entries are addressed by set then beat
    icache_ram #(
      .entry_t (beat_t),
      .Depth   (2 ** (SetsWidth + LineBeatsLog))
    ) u_data_ram (
      .clk_i     (clk_i),
      .rst_ni    (rst_ni),
      .rd_req_i  (rd.read_req),
      .rd_addr_i ({rd.set, rd.beat}),
      .rd_data_o (rd.data[i]),
      .wr_req_i  (wr_data_req && wr_ways[i]),
      .wr_addr_i ({wr_set, wr_beat}),
      .wr_data_i (wr_data)
    );

    assign rd.tag[i]   = rd_tag.tag;
    assign rd.valid[i] = rd_tag.valid;
  end

endmodule

// ==== icache_ctrl.sv ====
// Fetch FSM with acquire issue, replay after fill or flush and fault responses
`timescale 1ns/1ns

module icache_ctrl import icache_pkg::*; #(
  parameter int unsigned WaysWidth = 2,
  parameter int unsigned SetsWidth = 6
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  input  pc_t         req_pc_i,
  input  logic        req_flush_i,
  output logic        resp_valid_o,
  output resp_e       resp_kind_o,
  output instr_t      resp_instr_o,
  output logic        mem_a_valid_o,
  input  logic        mem_a_ready_i,
  output line_addr_t  mem_a_line_o,
  icache_rd_if.ctrl   rd,
  icache_fill_if.ctrl fill,
  output logic        flush_req_o,
  input  logic        flush_done_i,
  output logic        miss_o
);

  typedef enum logic [2:0] {
    StFlush,
    StIdle,
    StFetch,
    StFill,
    StReplay,
    StFault
  } state_e;

  state_e               state_q;
  state_e               state_d;
  pc_t                  pc_q;
  pc_t                  rd_pc;
  paddr_t               pa;
  beat_t                hit_beat;
  logic [WaysWidth-1:0] way_q;
  logic                 acq_pending_q;
  logic                 start_q;
  logic                 req_held_q;
  logic                 accept;
  logic                 out_of_range;

  assign req_ready_o  = state_q == StIdle;
  assign accept       = req_valid_i && req_ready_o;
  assign out_of_range = |req_pc_i[PcWidth-1:PhysAddrLen];

  ////////////////////////////////////////////////////////////////////////////
  // Array read and memory request
  ////////////////////////////////////////////////////////////////////////////

  // New PC on acceptance, held PC on replay
  assign rd_pc       = (state_q == StIdle) ? req_pc_i : pc_q;
  assign rd.set      = rd_pc[LineOffsetBits +: SetsWidth];
  assign rd.beat     = rd_pc[3 +: LineBeatsLog];
  assign rd.read_req = (accept && !req_flush_i && !out_of_range) || (state_q == StReplay);

  assign pa            = pc_q[PhysAddrLen-1:0];
  assign mem_a_line_o  = pa[PhysAddrLen-1:LineOffsetBits];
  assign mem_a_valid_o = acq_pending_q;

  assign fill.start = start_q;
  assign fill.line  = mem_a_line_o;
  assign fill.way   = way_q;

  assign flush_req_o = accept && req_flush_i && !out_of_range;
  assign miss_o      = (state_q == StFetch) && !(|rd.hit);

  ////////////////////////////////////////////////////////////////////////////
  // Response
  ////////////////////////////////////////////////////////////////////////////

  // Bit 2 picks the 32-bit half of the beat
  assign hit_beat     = rd.data[rd.hit_way];
  assign resp_instr_o = pc_q[2] ? hit_beat[32 +: 32] : hit_beat[0 +: 32];
  assign resp_kind_o  = (state_q == StFault) ? RespFault : RespInstr;
  assign resp_valid_o = ((state_q == StFetch) && (|rd.hit)) || (state_q == StFault);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      StFlush: begin
        if (flush_done_i) begin
          state_d = req_held_q ? StReplay : StIdle;
        end
      end
      StIdle: begin
        if (accept && out_of_range) begin
          state_d = StFault;
        end else if (accept && req_flush_i) begin
          state_d = StFlush;
        end else if (accept) begin
          state_d = StFetch;
        end
      end
      StFetch: begin
        state_d = (|rd.hit) ? StIdle : StFill;
      end
      StFill: begin
        if (fill.done) begin
          state_d = StReplay;
        end else if (fill.denied) begin
          state_d = StFault;
        end
      end
      StReplay: state_d = StFetch;
      StFault:  state_d = StIdle;
      default:  state_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= StFlush;
      acq_pending_q <= 1'b0;
      start_q       <= 1'b0;
      req_held_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      // Refill starts the cycle after the acquire is taken
      start_q <= acq_pending_q && mem_a_ready_i;
      if (miss_o) begin
        acq_pending_q <= 1'b1;
      end else if (mem_a_ready_i) begin
        acq_pending_q <= 1'b0;
      end
      if (accept) begin
        req_held_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      pc_q <= req_pc_i;
    end
    if (miss_o) begin
      way_q <= rd.hit_way;
    end
  end

endmodule

// ==== icache_flush.sv ====
// Set-by-set tag invalidation walker for reset and flush requests
`timescale 1ns/1ns

module icache_flush #(
  parameter int unsigned SetsWidth = 6
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        flush_req_i,
  output logic        flush_done_o,
  icache_wr_if.writer wr
);

  logic                 walking_q;
  logic [SetsWidth-1:0] idx_q;
  logic                 done_q;

  // All ways of one set are cleared per cycle
  assign wr.tag_req  = walking_q;
  assign wr.data_req = 1'b0;
  assign wr.way      = '1;
  assign wr.set      = idx_q;
  assign wr.beat     = '0;
  assign wr.tag      = '0;
  assign wr.valid    = 1'b0;
  assign wr.data     = '0;

  assign flush_done_o = done_q;

  // The walk begins straight out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      walking_q <= 1'b1;
      idx_q     <= '0;
      done_q    <= 1'b0;
    end else begin
      done_q <= walking_q && (&idx_q);
      if (walking_q) begin
        idx_q <= idx_q + 1'b1;
        if (&idx_q) begin
          walking_q <= 1'b0;
        end
      end else if (flush_req_i) begin
        walking_q <= 1'b1;
      end
    end
  end

endmodule

// ==== icache_if.sv ====
// Cache array write, array read and line fill coordination interfaces
`timescale 1ns/1ns

interface icache_wr_if import icache_pkg::*; #(
  parameter int unsigned WaysWidth = 2,
  parameter int unsigned SetsWidth = 6
) ();

  localparam int unsigned NumWays = 2 ** WaysWidth;
  localparam int unsigned TagWidth = PhysAddrLen - LineOffsetBits - SetsWidth;

  logic                    tag_req;
  logic                    data_req;
  logic [NumWays-1:0]      way;
  logic [SetsWidth-1:0]    set;
  logic [LineBeatsLog-1:0] beat;
  logic [TagWidth-1:0]     tag;
  logic                    valid;
  beat_t                   data;

  modport writer (output tag_req, data_req, way, set, beat, tag, valid, data);
  modport array  (input  tag_req, data_req, way, set, beat, tag, valid, data);

endinterface

interface icache_rd_if import icache_pkg::*; #(
  parameter int unsigned WaysWidth = 2,
  parameter int unsigned SetsWidth = 6
) ();

  localparam int unsigned NumWays = 2 ** WaysWidth;
  localparam int unsigned TagWidth = PhysAddrLen - LineOffsetBits - SetsWidth;

  logic                              read_req;
  logic [SetsWidth-1:0]              set;
  logic [LineBeatsLog-1:0]           beat;
  logic [NumWays-1:0][TagWidth-1:0]  tag;
  logic [NumWays-1:0]                valid;
  beat_t [NumWays-1:0]               data;
  logic [NumWays-1:0]                hit;
  logic [WaysWidth-1:0]              hit_way;

  modport ctrl   (output read_req, set, beat, input data, hit, hit_way);
  modport array  (input read_req, set, beat, output tag, valid, data);
  modport lookup (input tag, valid, output hit, hit_way);

endinterface

interface icache_fill_if import icache_pkg::*; #(
  parameter int unsigned WaysWidth = 2
) ();

  logic                 start;
  line_addr_t           line;
  logic [WaysWidth-1:0] way;
  logic                 done;
  logic                 denied;

  modport ctrl   (output start, line, way, input done, denied);
  modport refill (input start, line, way, output done, denied);

endinterface

// ==== icache_lookup.sv ====
// Tag compare with hit way, empty way or pseudo-FIFO victim selection
`timescale 1ns/1ns

module icache_lookup import icache_pkg::*; #(
  parameter int unsigned WaysWidth = 2,
  parameter int unsigned SetsWidth = 6
) (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  icache_rd_if.lookup                                   rd,
  input  logic [PhysAddrLen-LineOffsetBits-SetsWidth-1:0] pa_tag_i,
  input  logic                                          miss_i
);

  localparam int unsigned NumWays = 2 ** WaysWidth;

  logic [NumWays-1:0]   hit;
  logic [WaysWidth-1:0] way;
  logic [WaysWidth-1:0] fifo_q;

  always_comb begin
    for (int i = 0; i < NumWays; i++) begin
      hit[i] = rd.valid[i] && (rd.tag[i] == pa_tag_i);
    end
  end

  // Later loops override earlier choices, so a hit beats an empty way
  always_comb begin
    way = fifo_q;
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (!rd.valid[i]) begin
        way = WaysWidth'(i);
      end
    end
    for (int i = NumWays - 1; i >= 0; i--) begin
      if (hit[i]) begin
        way = WaysWidth'(i);
      end
    end
  end

  assign rd.hit     = hit;
  assign rd.hit_way = way;

  // Global pointer, moves on every miss
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fifo_q <= '0;
    end else if (miss_i) begin
      fifo_q <= fifo_q + 1'b1;
    end
  end

endmodule

// ==== icache_pkg.sv ====
// Instruction cache shared widths, line geometry, scalar types and response kinds
package icache_pkg;

  // Fetch address width from the core
  localparam int unsigned PcWidth = 64;

  // Physical address space width, upper PC bits above this fault
  localparam int unsigned PhysAddrLen = 32;

  // Memory beat width, also the data RAM entry width
  localparam int unsigned BeatWidth = 64;

  // A 64-byte line is eight beats
  localparam int unsigned LineBeatsLog = 3;
  localparam int unsigned LineOffsetBits = 6;

  typedef logic [PcWidth-1:0] pc_t;
  typedef logic [PhysAddrLen-1:0] paddr_t;
  typedef logic [BeatWidth-1:0] beat_t;
  typedef logic [31:0] instr_t;
  typedef logic [PhysAddrLen-LineOffsetBits-1:0] line_addr_t;

  typedef enum logic {
    RespInstr,
    RespFault
  } resp_e;

endpackage

// ==== icache_ram.sv ====
// Two-port RAM with one-cycle read latency and same-address write bypass
`timescale 1ns/1ns

module icache_ram #(
  parameter type         entry_t = logic,
  parameter int unsigned Depth   = 64
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     rd_req_i,
  input  logic [$clog2(Depth)-1:0] rd_addr_i,
  output entry_t                   rd_data_o,
  input  logic                     wr_req_i,
  input  logic [$clog2(Depth)-1:0] wr_addr_i,
  input  entry_t                   wr_data_i
);

  entry_t mem_q [Depth];
  entry_t rd_q;
  entry_t bypass_q;
  logic   bypass_valid_q;

  always_ff @(posedge clk_i) begin
    if (wr_req_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
    if (rd_req_i) begin
      rd_q <= mem_q[rd_addr_i];
    end
    if (rd_req_i && wr_req_i) begin
      bypass_q <= wr_data_i;
    end
  end

  // A write to the address being read wins over the stored entry
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bypass_valid_q <= 1'b0;
    end else if (rd_req_i) begin
      bypass_valid_q <= wr_req_i && (wr_addr_i == rd_addr_i);
    end
  end

  assign rd_data_o = bypass_valid_q ? bypass_q : rd_q;

endmodule

// ==== icache_refill.sv ====
// Line refill collecting grant beats into the victim way
`timescale 1ns/1ns

module icache_refill import icache_pkg::*; #(
  parameter int unsigned WaysWidth = 2,
  parameter int unsigned SetsWidth = 6
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  icache_fill_if.refill fill,
  icache_wr_if.writer   wr,
  input  logic          mem_d_valid_i,
  output logic          mem_d_ready_o,
  input  beat_t         mem_d_data_i,
  input  logic          mem_d_denied_i
);

  localparam int unsigned NumWays = 2 ** WaysWidth;

  typedef enum logic {
    RfIdle,
    RfCollect
  } refill_state_e;

  refill_state_e           state_q;
  logic [LineBeatsLog-1:0] cnt_q;
  line_addr_t              line_q;
  logic [WaysWidth-1:0]    way_q;
  logic                    beat_fire;
  logic                    deny;
  logic                    last;

  assign mem_d_ready_o = state_q == RfCollect;
  assign beat_fire     = mem_d_valid_i && mem_d_ready_o;

  // Only a denied first beat aborts the line
  assign deny = beat_fire && mem_d_denied_i && (cnt_q == '0);
  assign last = beat_fire && !deny && (&cnt_q);

  assign fill.done   = last;
  assign fill.denied = deny;

  ////////////////////////////////////////////////////////////////////////////
  // Array writes
  ////////////////////////////////////////////////////////////////////////////

  assign wr.data_req = beat_fire && !deny;
  assign wr.tag_req  = last;
  assign wr.way      = NumWays'(1) << way_q;
  assign wr.set      = line_q[SetsWidth-1:0];
  assign wr.beat     = cnt_q;
  assign wr.tag      = line_q[$bits(line_addr_t)-1:SetsWidth];
  assign wr.valid    = 1'b1;
  assign wr.data     = mem_d_data_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RfIdle;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        RfIdle: begin
          if (fill.start) begin
            state_q <= RfCollect;
            cnt_q   <= '0;
          end
        end
        RfCollect: begin
          if (beat_fire) begin
            cnt_q <= cnt_q + 1'b1;
          end
          if (deny || last) begin
            state_q <= RfIdle;
          end
        end
        default: state_q <= RfIdle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill.start) begin
      line_q <= fill.line;
      way_q  <= fill.way;
    end
  end

endmodule

// ==== icache_tb.sv ====
// Instruction cache testbench with a memory grant model and table-driven fetches
`timescale 1ns/1ns

module icache_tb import icache_pkg::*; #(
  parameter int unsigned WaysWidth = 2,
  parameter int unsigned SetsWidth = 6
) ();

  localparam int unsigned NumRows    = 17;
  localparam int unsigned CycleLimit = NumRows * 60 + 2 ** SetsWidth + 100;
  localparam instr_t      MemKey     = 32'h5a3c_96e1;
  localparam int unsigned DenyBit    = 24 - LineOffsetBits;
  localparam int unsigned LastBeat   = (1 << LineBeatsLog) - 1;

  typedef struct {
    pc_t    pc;
    logic   flush;
    resp_e  kind;
    instr_t instr;
    logic   acquire;
  } row_t;

  logic       clk_i;
  logic       rst_ni;
  logic       req_valid_i;
  logic       req_ready_o;
  pc_t        req_pc_i;
  logic       req_flush_i;
  logic       resp_valid_o;
  resp_e      resp_kind_o;
  instr_t     resp_instr_o;
  logic       mem_a_valid_o;
  logic       mem_a_ready_i  = 1'b0;
  line_addr_t mem_a_line_o;
  logic       mem_d_valid_i  = 1'b0;
  logic       mem_d_ready_o;
  beat_t      mem_d_data_i   = '0;
  logic       mem_d_denied_i = 1'b0;

  integer      seed       = 71030;
  int unsigned cycles     = 0;
  int unsigned acq_count  = 0;
  line_addr_t  acq_line   = '0;
  logic        granting   = 1'b0;
  logic        beat_taken = 1'b0;
  int unsigned beat_idx   = 0;
  row_t        rows [NumRows];
  int unsigned row_cnt    = 0;

  icache_top #(
    .WaysWidth (WaysWidth),
    .SetsWidth (SetsWidth)
  ) u_icache_top (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .req_pc_i       (req_pc_i),
    .req_flush_i    (req_flush_i),
    .resp_valid_o   (resp_valid_o),
    .resp_kind_o    (resp_kind_o),
    .resp_instr_o   (resp_instr_o),
    .mem_a_valid_o  (mem_a_valid_o),
    .mem_a_ready_i  (mem_a_ready_i),
    .mem_a_line_o   (mem_a_line_o),
    .mem_d_valid_i  (mem_d_valid_i),
    .mem_d_ready_o  (mem_d_ready_o),
    .mem_d_data_i   (mem_d_data_i),
    .mem_d_denied_i (mem_d_denied_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory content and result checks
  ////////////////////////////////////////////////////////////////////////////

  // Each word holds its own byte address xor the key
  function automatic instr_t mem_word(paddr_t addr);
    return {addr[PhysAddrLen-1:2], 2'b00} ^ MemKey;
  endfunction

  function automatic beat_t line_beat(line_addr_t line, int unsigned beat);
    paddr_t addr;
    addr = {line, LineOffsetBits'(beat * 8)};
    return {mem_word(addr + 32'd4), mem_word(addr)};
  endfunction

  task automatic fail_and_stop();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_kind(resp_e got, resp_e exp, int unsigned row);
    if (got !== exp) begin
      $display("MISMATCH time %0t: row %0d response kind %s, expected %s",
               $time, row, got.name(), exp.name());
      fail_and_stop();
    end
  endtask

  task automatic check_instr(instr_t got, instr_t exp, int unsigned row);
    if (got !== exp) begin
      $display("MISMATCH time %0t: row %0d instruction %h, expected %h",
               $time, row, got, exp);
      fail_and_stop();
    end
  endtask

  task automatic check_line(line_addr_t got, line_addr_t exp, int unsigned row);
    if (got !== exp) begin
      $display("MISMATCH time %0t: row %0d acquire line %h, expected %h",
               $time, row, got, exp);
      fail_and_stop();
    end
  endtask

  task automatic check_count(int got, int exp, string what, int unsigned row);
    if (got != exp) begin
      $display("MISMATCH time %0t: row %0d %s %0d, expected %0d",
               $time, row, what, got, exp);
      fail_and_stop();
    end
  endtask

  task automatic add_row(pc_t pc, logic flush, resp_e kind, logic acquire);
    rows[row_cnt].pc      = pc;
    rows[row_cnt].flush   = flush;
    rows[row_cnt].kind    = kind;
    rows[row_cnt].instr   = (kind == RespInstr) ? mem_word(pc[PhysAddrLen-1:0]) : '0;
    rows[row_cnt].acquire = acquire;
    row_cnt++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model and timeout
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (granting) begin
      mem_a_ready_i = 1'b0;
      // An offered beat stays until taken, gaps only fall between beats
      if (!(mem_d_valid_i && !beat_taken) && ($random(seed) % 4 == 0)) begin
        mem_d_valid_i = 1'b0;
      end else begin
        mem_d_valid_i  = 1'b1;
        mem_d_denied_i = acq_line[DenyBit];
        mem_d_data_i   = line_beat(acq_line, beat_idx);
      end
      // Ready only moves on the rising edge, so the transfer is known here
      beat_taken = mem_d_valid_i && mem_d_ready_o;
      if (beat_taken) begin
        if (acq_line[DenyBit] || beat_idx == LastBeat) begin
          granting = 1'b0;
        end
        beat_idx++;
      end
    end else begin
      mem_d_valid_i  = 1'b0;
      mem_d_denied_i = 1'b0;
      mem_a_ready_i  = ($random(seed) % 3 != 0);
      if (mem_a_valid_o && mem_a_ready_i) begin
        acq_line   = mem_a_line_o;
        acq_count++;
        granting   = 1'b1;
        beat_idx   = 0;
        beat_taken = 1'b0;
      end
    end
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Timeout: the cache gave no response within %0d cycles", CycleLimit);
      fail_and_stop();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Fetch sequence
  ////////////////////////////////////////////////////////////////////////////

  task automatic apply_row(int unsigned r);
    int unsigned acq_before;
    int unsigned wait_cycles;
    while (!req_ready_o) begin
      @(negedge clk_i);
    end
    acq_before  = acq_count;
    req_valid_i = 1'b1;
    req_pc_i    = rows[r].pc;
    req_flush_i = rows[r].flush;
    @(negedge clk_i);
    req_valid_i = 1'b0;
    req_flush_i = 1'b0;
    wait_cycles = 0;
    while (!resp_valid_o) begin
      @(negedge clk_i);
      wait_cycles++;
    end
    check_kind(resp_kind_o, rows[r].kind, r);
    if (rows[r].kind == RespInstr) begin
      check_instr(resp_instr_o, rows[r].instr, r);
    end
    check_count(int'(acq_count - acq_before), int'(rows[r].acquire), "acquire count", r);
    if (rows[r].acquire) begin
      check_line(acq_line, rows[r].pc[PhysAddrLen-1:LineOffsetBits], r);
    end else if (!rows[r].flush) begin
      // Hits and range faults answer in the cycle right after acceptance
      check_count(int'(wait_cycles), 0, "response latency", r);
    end
    @(negedge clk_i);
  endtask

  initial begin
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_pc_i    = '0;
    req_flush_i = 1'b0;

    // Cold miss then hits in the same line
    add_row(64'h0000_0000_0000_1008, 1'b0, RespInstr, 1'b1);
    add_row(64'h0000_0000_0000_100c, 1'b0, RespInstr, 1'b0);
    add_row(64'h0000_0000_0000_1038, 1'b0, RespInstr, 1'b0);
    add_row(64'h0000_0000_0000_1000, 1'b0, RespInstr, 1'b0);
    // Denied line, nothing cached so the refetch asks memory again
    add_row(64'h0000_0000_0100_0200, 1'b0, RespFault, 1'b1);
    add_row(64'h0000_0000_0100_0200, 1'b0, RespFault, 1'b1);
    // Fourth miss so the FIFO pointer is back at way 0
    add_row(64'h0000_0000_0000_1040, 1'b0, RespInstr, 1'b1);
    // Five lines in set 5, the last evicts way 0
    add_row(64'h0000_0000_0000_2140, 1'b0, RespInstr, 1'b1);
    add_row(64'h0000_0000_0000_3144, 1'b0, RespInstr, 1'b1);
    add_row(64'h0000_0000_0000_4148, 1'b0, RespInstr, 1'b1);
    add_row(64'h0000_0000_0000_514c, 1'b0, RespInstr, 1'b1);
    add_row(64'h0000_0000_0000_6150, 1'b0, RespInstr, 1'b1);
    add_row(64'h0000_0000_0000_6154, 1'b0, RespInstr, 1'b0);
    add_row(64'h0000_0000_0000_2140, 1'b0, RespInstr, 1'b1);
    // Out of range PC
    add_row(64'h0000_0001_0000_1000, 1'b0, RespFault, 1'b0);
    // Flush drops the cached line at 0x1000
    add_row(64'h0000_0000_0000_1004, 1'b1, RespInstr, 1'b1);
    add_row(64'h0000_0000_0000_1004, 1'b0, RespInstr, 1'b0);

    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    for (int unsigned r = 0; r < row_cnt; r++) begin
      apply_row(r);
    end

    @(negedge clk_i);
    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== icache_tb_asserts.sv ====
// Concurrent checks on the cache request, response and acquire handshakes
`timescale 1ns/1ns

module icache_tb_asserts import icache_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       req_valid_i,
  input logic       req_ready_o,
  input logic       req_flush_i,
  input logic       resp_valid_o,
  input logic       mem_a_valid_o,
  input logic       mem_a_ready_i,
  input line_addr_t mem_a_line_o
);

  logic plain_accept_q;

  // Accepted fetch without flush, its answer or miss shows next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      plain_accept_q <= 1'b0;
    end else begin
      plain_accept_q <= req_valid_i && req_ready_o && !req_flush_i;
    end
  end

  a_acquire_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_a_valid_o && !mem_a_ready_i |=> mem_a_valid_o && $stable(mem_a_line_o))
    else $error("Acquire dropped or changed before it was taken");

  a_no_resp_on_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && req_ready_o |-> !resp_valid_o)
    else $error("Response raised in a cycle that accepts a new fetch");

  a_quiet_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !resp_valid_o)
    else $error("Response raised in the first cycle after reset");

  // No answer one cycle after acceptance means the fetch missed
  a_hit_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    plain_accept_q && !resp_valid_o |=> mem_a_valid_o)
    else $error("Fetch neither answered after one cycle nor sent to memory");

endmodule

bind icache_top icache_tb_asserts u_asserts (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .req_valid_i   (req_valid_i),
  .req_ready_o   (req_ready_o),
  .req_flush_i   (req_flush_i),
  .resp_valid_o  (resp_valid_o),
  .mem_a_valid_o (mem_a_valid_o),
  .mem_a_ready_i (mem_a_ready_i),
  .mem_a_line_o  (mem_a_line_o)
);

// ==== icache_top.sv ====
// Instruction cache top level joining controller, arrays, lookup, refill and flush
`timescale 1ns/1ns

module icache_top import icache_pkg::*; #(
  parameter int unsigned WaysWidth = 2,
  parameter int unsigned SetsWidth = 6
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  pc_t        req_pc_i,
  input  logic       req_flush_i,
  output logic       resp_valid_o,
  output resp_e      resp_kind_o,
  output instr_t     resp_instr_o,
  output logic       mem_a_valid_o,
  input  logic       mem_a_ready_i,
  output line_addr_t mem_a_line_o,
  input  logic       mem_d_valid_i,
  output logic       mem_d_ready_o,
  input  beat_t      mem_d_data_i,
  input  logic       mem_d_denied_i
);

  logic flush_req;
  logic flush_done;
  logic miss;

  icache_wr_if #(.WaysWidth(WaysWidth), .SetsWidth(SetsWidth)) flush_wr ();
  icache_wr_if #(.WaysWidth(WaysWidth), .SetsWidth(SetsWidth)) refill_wr ();
  icache_rd_if #(.WaysWidth(WaysWidth), .SetsWidth(SetsWidth)) rd ();
  icache_fill_if #(.WaysWidth(WaysWidth)) fill ();

  icache_ctrl #(
    .WaysWidth (WaysWidth),
    .SetsWidth (SetsWidth)
  ) u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_pc_i      (req_pc_i),
    .req_flush_i   (req_flush_i),
    .resp_valid_o  (resp_valid_o),
    .resp_kind_o   (resp_kind_o),
    .resp_instr_o  (resp_instr_o),
    .mem_a_valid_o (mem_a_valid_o),
    .mem_a_ready_i (mem_a_ready_i),
    .mem_a_line_o  (mem_a_line_o),
    .rd            (rd),
    .fill          (fill),
    .flush_req_o   (flush_req),
    .flush_done_i  (flush_done),
    .miss_o        (miss)
  );

  icache_arrays #(
    .WaysWidth (WaysWidth),
    .SetsWidth (SetsWidth)
  ) u_arrays (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .flush_wr  (flush_wr),
    .refill_wr (refill_wr),
    .rd        (rd)
  );

  // The held line address doubles as the lookup tag source
  icache_lookup #(
    .WaysWidth (WaysWidth),
    .SetsWidth (SetsWidth)
  ) u_lookup (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .rd       (rd),
    .pa_tag_i (mem_a_line_o[$bits(line_addr_t)-1:SetsWidth]),
    .miss_i   (miss)
  );

  icache_refill #(
    .WaysWidth (WaysWidth),
    .SetsWidth (SetsWidth)
  ) u_refill (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fill           (fill),
    .wr             (refill_wr),
    .mem_d_valid_i  (mem_d_valid_i),
    .mem_d_ready_o  (mem_d_ready_o),
    .mem_d_data_i   (mem_d_data_i),
    .mem_d_denied_i (mem_d_denied_i)
  );

  icache_flush #(
    .SetsWidth (SetsWidth)
  ) u_flush (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_req_i  (flush_req),
    .flush_done_o (flush_done),
    .wr           (flush_wr)
  );

endmodule
